//--- design/alarm_unit.sv
`timescale 1ns/100ps

module alarm_unit
  import clock_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_tone_tick,
  input  logic     i_alarm_en,
  input  hms_val_t i_time_sec,
  input  hms_val_t i_time_min,
  input  hms_val_t i_time_hour,
  input  hms_val_t i_alarm_sec,
  input  hms_val_t i_alarm_min,
  input  hms_val_t i_alarm_hour,
  output logic     o_alarm
);

  logic match;
  logic ringing;
  logic tone;

  assign match = (i_time_sec == i_alarm_sec) && (i_time_min == i_alarm_min) &&
                 (i_time_hour == i_alarm_hour);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ringing <= 1'b0;
      tone    <= 1'b0;
    end else begin
      if (!i_alarm_en) begin
        ringing <= 1'b0;
      end else if (match) begin
        ringing <= 1'b1;  // Holds until alarm is switched off
      end
      if (!ringing) begin
        tone <= 1'b0;
      end else if (i_tone_tick) begin
        tone <= ~tone;
      end
    end
  end

  assign o_alarm = tone;

endmodule

//--- design/button_sync.sv
`timescale 1ns/100ps

module button_sync
  import clock_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_sample_tick,
  input  logic [NUM_BTNS-1:0] i_btn,
  output logic [NUM_BTNS-1:0] o_press
);

  logic [NUM_BTNS-1:0] meta;
  logic [NUM_BTNS-1:0] sync;
  logic [NUM_BTNS-1:0] hist0;  // Latest sample
  logic [NUM_BTNS-1:0] hist1;  // Sample before that

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta    <= '0;
      sync    <= '0;
      hist0   <= '0;
      hist1   <= '0;
      o_press <= '0;
    end else begin
      meta <= i_btn;
      sync <= meta;
      if (i_sample_tick) begin
        hist0 <= sync;
        hist1 <= hist0;
        // Two high samples in a row after a low one
        o_press <= sync & hist0 & ~hist1;
      end else begin
        o_press <= '0;
      end
    end
  end

endmodule

//--- design/clock_ctrl.sv
`timescale 1ns/100ps

module clock_ctrl
  import clock_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_BTNS-1:0] i_press,
  output mode_t               o_mode,
  output field_t              o_field,
  output logic                o_alarm_en,
  output logic                o_run_en,
  output logic                o_time_step,
  output logic                o_alarm_step
);

  mode_t  mode_next;
  field_t field_next;

  // --------------------------------------------------
  // Mode and position sequencing
  // --------------------------------------------------
  always_comb begin
    case (o_mode)
      MODE_CLOCK:    mode_next = MODE_SET_TIME;
      MODE_SET_TIME: mode_next = MODE_SET_ALARM;
      default:       mode_next = MODE_CLOCK;
    endcase
  end

  always_comb begin
    case (o_field)
      FIELD_SEC: field_next = FIELD_MIN;
      FIELD_MIN: field_next = FIELD_HOUR;
      default:   field_next = FIELD_SEC;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_mode     <= MODE_CLOCK;
      o_field    <= FIELD_SEC;
      o_alarm_en <= 1'b0;
    end else begin
      if (i_press[BTN_MODE]) begin
        o_mode <= mode_next;
      end
      if (i_press[BTN_POS]) begin
        o_field <= field_next;
      end
      if (i_press[BTN_ALARM]) begin
        o_alarm_en <= ~o_alarm_en;
      end
    end
  end

  // --------------------------------------------------
  // Counter enables
  // --------------------------------------------------
  assign o_run_en = (o_mode != MODE_SET_TIME);  // Clock frozen while setting time

  // Step press ignored in normal clock mode
  assign o_time_step  = i_press[BTN_STEP] && (o_mode == MODE_SET_TIME);
  assign o_alarm_step = i_press[BTN_STEP] && (o_mode == MODE_SET_ALARM);

endmodule

//--- design/clock_pkg.sv
package clock_pkg;

  // --------------------------------------------------
  // Modes and set position
  // --------------------------------------------------
  typedef enum logic [1:0] {
    MODE_CLOCK     = 2'd0,
    MODE_SET_TIME  = 2'd1,
    MODE_SET_ALARM = 2'd2
  } mode_t;

  typedef enum logic [1:0] {
    FIELD_SEC  = 2'd0,
    FIELD_MIN  = 2'd1,
    FIELD_HOUR = 2'd2
  } field_t;

  typedef logic [5:0] hms_val_t;  // One h/m/s field
  typedef logic [3:0] digit_t;
  typedef logic [6:0] seg_t;      // {a..g}, active high

  localparam hms_val_t SEC_MAX  = 6'd59;
  localparam hms_val_t MIN_MAX  = 6'd59;
  localparam hms_val_t HOUR_MAX = 6'd23;

  localparam int NUM_DIGITS = 6;
  localparam int NUM_BTNS   = 4;

  // Button positions in i_btn
  localparam int BTN_MODE  = 0;
  localparam int BTN_POS   = 1;
  localparam int BTN_STEP  = 2;
  localparam int BTN_ALARM = 3;

endpackage

//--- design/digit_scan.sv
`timescale 1ns/100ps

module digit_scan
  import clock_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_scan_tick,
  input  logic                  i_blink_on,
  input  mode_t                 i_mode,
  input  field_t                i_field,
  input  hms_val_t              i_time_sec,
  input  hms_val_t              i_time_min,
  input  hms_val_t              i_time_hour,
  input  hms_val_t              i_alarm_sec,
  input  hms_val_t              i_alarm_min,
  input  hms_val_t              i_alarm_hour,
  output seg_t                  o_seg,
  output logic                  o_seg_dp,
  output logic [NUM_DIGITS-1:0] o_seg_enb
);

  logic [2:0]            digit;    // 0 = seconds ones .. 5 = hours tens
  hms_val_t              fval;
  digit_t                num;
  logic                  blank;
  logic                  dp_next;
  logic [NUM_DIGITS-1:0] one_hot;

  function automatic seg_t seg_dec(digit_t d);
    case (d)
      4'd0:    return 7'b111_1110;
      4'd1:    return 7'b011_0000;
      4'd2:    return 7'b110_1101;
      4'd3:    return 7'b111_1001;
      4'd4:    return 7'b011_0011;
      4'd5:    return 7'b101_1011;
      4'd6:    return 7'b101_1111;
      4'd7:    return 7'b111_0000;
      4'd8:    return 7'b111_1111;
      4'd9:    return 7'b111_0011;
      default: return 7'b000_0000;
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      digit <= '0;
    end else if (i_scan_tick) begin
      digit <= (digit == 3'(NUM_DIGITS - 1)) ? 3'd0 : digit + 3'd1;
    end
  end

  // --------------------------------------------------
  // Source select and digit split
  // --------------------------------------------------
  always_comb begin
    case (digit[2:1])
      2'd0:    fval = (i_mode == MODE_SET_ALARM) ? i_alarm_sec : i_time_sec;
      2'd1:    fval = (i_mode == MODE_SET_ALARM) ? i_alarm_min : i_time_min;
      default: fval = (i_mode == MODE_SET_ALARM) ? i_alarm_hour : i_time_hour;
    endcase
  end

  assign num = digit[0] ? digit_t'(fval / 6'd10) : digit_t'(fval % 6'd10);

  // Field being set blinks
  assign blank = (i_mode != MODE_CLOCK) && (i_field == field_t'(digit[2:1])) && i_blink_on;

  always_comb begin
    case (digit)
      3'd0:    dp_next = i_mode[0];
      3'd1:    dp_next = i_mode[1];
      default: dp_next = 1'b0;
    endcase
  end

  assign one_hot = {{(NUM_DIGITS-1){1'b0}}, 1'b1} << digit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_seg     <= '0;
      o_seg_dp  <= 1'b0;
      o_seg_enb <= {{(NUM_DIGITS-1){1'b1}}, 1'b0};
    end else begin
      o_seg     <= blank ? seg_t'(0) : seg_dec(num);
      o_seg_dp  <= dp_next;
      o_seg_enb <= ~one_hot;  // Active low
    end
  end

endmodule

//--- design/digital_clock.sv
`timescale 1ns/100ps

module digital_clock
  import clock_pkg::*;
#(
  parameter int unsigned SEC_DIV   = 50_000_000,
  parameter int unsigned DEB_DIV   = 500_000,     // 10 ms sampling
  parameter int unsigned SCAN_DIV  = 50_000,
  parameter int unsigned BLINK_DIV = 12_500_000,
  parameter int unsigned TONE_DIV  = 25_000       // About 1 kHz tone
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [NUM_BTNS-1:0]   i_btn,
  output seg_t                  o_seg,
  output logic                  o_seg_dp,
  output logic [NUM_DIGITS-1:0] o_seg_enb,
  output logic                  o_alarm
);

  logic sec_tick, sample_tick, scan_tick, tone_tick, blink_on;
  logic [NUM_BTNS-1:0] press;
  mode_t    mode;
  field_t   field;
  logic     alarm_en, run_en, time_step, alarm_step, time_tick;
  hms_val_t time_sec, time_min, time_hour;
  hms_val_t alarm_sec, alarm_min, alarm_hour;

  tick_gen #(
    .SEC_DIV(SEC_DIV), .DEB_DIV(DEB_DIV), .SCAN_DIV(SCAN_DIV),
    .BLINK_DIV(BLINK_DIV), .TONE_DIV(TONE_DIV)
  ) u_tick_gen (
    .clk(clk), .rst_n(rst_n), .o_sec_tick(sec_tick), .o_sample_tick(sample_tick),
    .o_scan_tick(scan_tick), .o_tone_tick(tone_tick), .o_blink_on(blink_on)
  );

  button_sync u_button_sync (
    .clk(clk), .rst_n(rst_n), .i_sample_tick(sample_tick), .i_btn(i_btn), .o_press(press)
  );

  clock_ctrl u_clock_ctrl (
    .clk(clk), .rst_n(rst_n), .i_press(press), .o_mode(mode), .o_field(field),
    .o_alarm_en(alarm_en), .o_run_en(run_en), .o_time_step(time_step),
    .o_alarm_step(alarm_step)
  );

  assign time_tick = sec_tick & run_en;

  hms_counter u_time (
    .clk(clk), .rst_n(rst_n), .i_tick(time_tick), .i_step(time_step), .i_field(field),
    .o_sec(time_sec), .o_min(time_min), .o_hour(time_hour)
  );

  // Alarm time only moves by stepping
  hms_counter u_alarm (
    .clk(clk), .rst_n(rst_n), .i_tick(1'b0), .i_step(alarm_step), .i_field(field),
    .o_sec(alarm_sec), .o_min(alarm_min), .o_hour(alarm_hour)
  );

  alarm_unit u_alarm_unit (
    .clk(clk), .rst_n(rst_n), .i_tone_tick(tone_tick), .i_alarm_en(alarm_en),
    .i_time_sec(time_sec), .i_time_min(time_min), .i_time_hour(time_hour),
    .i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
    .o_alarm(o_alarm)
  );

  digit_scan u_digit_scan (
    .clk(clk), .rst_n(rst_n), .i_scan_tick(scan_tick), .i_blink_on(blink_on),
    .i_mode(mode), .i_field(field),
    .i_time_sec(time_sec), .i_time_min(time_min), .i_time_hour(time_hour),
    .i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hour(alarm_hour),
    .o_seg(o_seg), .o_seg_dp(o_seg_dp), .o_seg_enb(o_seg_enb)
  );

endmodule

//--- design/hms_counter.sv
`timescale 1ns/100ps

module hms_counter
  import clock_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_tick,
  input  logic     i_step,
  input  field_t   i_field,
  output hms_val_t o_sec,
  output hms_val_t o_min,
  output hms_val_t o_hour
);

  function automatic hms_val_t inc_wrap(hms_val_t val, hms_val_t lim);
    return (val >= lim) ? hms_val_t'(0) : val + hms_val_t'(1);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_sec  <= '0;
      o_min  <= '0;
      o_hour <= '0;
    end else if (i_tick) begin
      o_sec <= inc_wrap(o_sec, SEC_MAX);
      if (o_sec == SEC_MAX) begin
        o_min <= inc_wrap(o_min, MIN_MAX);
        if (o_min == MIN_MAX) begin
          o_hour <= inc_wrap(o_hour, HOUR_MAX);  // 23:59:59 rolls to 00:00:00
        end
      end
    end else if (i_step) begin
      // Single field only, no carry
      case (i_field)
        FIELD_SEC:  o_sec  <= inc_wrap(o_sec, SEC_MAX);
        FIELD_MIN:  o_min  <= inc_wrap(o_min, MIN_MAX);
        FIELD_HOUR: o_hour <= inc_wrap(o_hour, HOUR_MAX);
        default: ;
      endcase
    end
  end

endmodule

//--- design/tick_gen.sv
`timescale 1ns/100ps

module tick_gen #(
  parameter int unsigned SEC_DIV   = 50_000_000,
  parameter int unsigned DEB_DIV   = 500_000,
  parameter int unsigned SCAN_DIV  = 50_000,
  parameter int unsigned BLINK_DIV = 12_500_000,
  parameter int unsigned TONE_DIV  = 25_000
) (
  input  logic clk,
  input  logic rst_n,
  output logic o_sec_tick,
  output logic o_sample_tick,
  output logic o_scan_tick,
  output logic o_tone_tick,
  output logic o_blink_on
);

  localparam int NUM_DIV = 5;
  // Index order is sec, sample, scan, blink, tone
  localparam logic [NUM_DIV-1:0][31:0] DIV_TAB =
    {TONE_DIV, BLINK_DIV, SCAN_DIV, DEB_DIV, SEC_DIV};

  logic [NUM_DIV-1:0] tick;

  for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
    logic [31:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt <= '0;
      end else if (tick[i]) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 32'd1;
      end
    end

    assign tick[i] = (cnt == DIV_TAB[i] - 32'd1);  // Last count of the period
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_blink_on <= 1'b0;
    end else if (tick[3]) begin
      o_blink_on <= ~o_blink_on;
    end
  end

  assign o_sec_tick    = tick[0];
  assign o_sample_tick = tick[1];
  assign o_scan_tick   = tick[2];
  assign o_tone_tick   = tick[4];

endmodule

//--- digital_clock.f
design/clock_pkg.sv
design/tick_gen.sv
design/button_sync.sv
design/clock_ctrl.sv
design/hms_counter.sv
design/alarm_unit.sv
design/digit_scan.sv
design/digital_clock.sv
verif/tb_digital_clock.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_digital_clock \
  -f digital_clock.f -o sim
./obj_dir/sim > sim.log
cat sim.log
if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
grep -q ">>> PASS" sim.log

//--- verif/tb_digital_clock.sv
`timescale 1ns/100ps

module tb_digital_clock
  import clock_pkg::*;
();

  localparam int SEC_DIV   = 200;
  localparam int DEB_DIV   = 2;
  localparam int SCAN_DIV  = 4;
  localparam int BLINK_DIV = 100;   // Half a second, so blink phase is fixed per read
  localparam int TONE_DIV  = 8;
  localparam int ALIGN_OFS = 4;     // Cycles after a second boundary
  localparam int CYC_LIMIT = SEC_DIV * 420;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [NUM_BTNS-1:0]   btn;
  seg_t                  seg;
  logic                  seg_dp;
  logic [NUM_DIGITS-1:0] seg_enb;
  logic                  alarm;

  int          cyc;
  int          run_secs;   // Seconds counted while running
  int          hour_ofs;   // Hour steps made in set-time mode
  int          al_h;
  int          al_m;
  int          al_s;
  int          err_cnt;
  int          test_err;
  bit          model_run;
  bit          en_model;
  bit          ring_model;
  logic [31:0] lfsr = 32'h4ff4;
  int          shown [NUM_DIGITS];
  bit          dps [NUM_DIGITS];

  digital_clock #(
    .SEC_DIV(SEC_DIV), .DEB_DIV(DEB_DIV), .SCAN_DIV(SCAN_DIV),
    .BLINK_DIV(BLINK_DIV), .TONE_DIV(TONE_DIV)
  ) u_dut (
    .clk(clk), .rst_n(rst_n), .i_btn(btn), .o_seg(seg), .o_seg_dp(seg_dp),
    .o_seg_enb(seg_enb), .o_alarm(alarm)
  );

  always #20 clk = ~clk;

  function automatic int cur_hour();
    return (run_secs / 3600 + hour_ofs) % 24;
  endfunction

  function automatic int cur_min();
    return (run_secs / 60) % 60;
  endfunction

  function automatic int cur_sec();
    return run_secs % 60;
  endfunction

  function int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      val = (val << 1) | int'(lfsr[0]);
    end
    return val;
  endfunction

  // 10 means blank, 15 an unknown pattern
  function automatic int seg_to_digit(input seg_t s);
    case (s)
      7'h7e:   return 0;
      7'h30:   return 1;
      7'h6d:   return 2;
      7'h79:   return 3;
      7'h33:   return 4;
      7'h5b:   return 5;
      7'h5f:   return 6;
      7'h70:   return 7;
      7'h7f:   return 8;
      7'h73:   return 9;
      7'h00:   return 10;
      default: return 15;
    endcase
  endfunction

  // --------------------------------------------------
  // Time and alarm model
  // --------------------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc        <= 0;
      run_secs   <= 0;
      ring_model <= 1'b0;
    end else begin
      cyc <= cyc + 1;
      if ((cyc + 1) % SEC_DIV == 0 && model_run) begin
        run_secs <= run_secs + 1;
      end
      ring_model <= en_model && (ring_model ||
                    (cur_hour() == al_h && cur_min() == al_m && cur_sec() == al_s));
    end
  end

  always @(posedge clk) begin
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout: no result after %0d cycles", CYC_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  alarm_quiet: assert property (@(posedge clk) disable iff (!rst_n) !ring_model |-> !alarm)
    else begin
      err_cnt = err_cnt + 1;
      $display("Error at %0t: o_alarm expected 0 got %b", $time, alarm);
    end

  task automatic press(input int b);
    @(negedge clk);
    while ((cyc % SEC_DIV) != ALIGN_OFS) @(negedge clk);
    btn[b] = 1'b1;
    repeat (4 * DEB_DIV) @(negedge clk);
    btn[b] = 1'b0;
    repeat (4 * DEB_DIV) @(negedge clk);
  endtask

  // Phase 0 reads with blink low, phase 1 with blink high
  task automatic read_display(input int phase);
    int                  idx;
    int                  prev;
    bit [NUM_DIGITS-1:0] seen;
    prev = -1;
    seen = '0;
    @(negedge clk);
    while ((cyc % SEC_DIV) != ALIGN_OFS + phase * BLINK_DIV) @(negedge clk);
    repeat ((NUM_DIGITS + 1) * SCAN_DIV) begin
      idx = -1;
      for (int i = 0; i < NUM_DIGITS; i++) begin
        if (seg_enb == ~(NUM_DIGITS'(1) << i)) idx = i;
      end
      assert (idx >= 0) else begin
        err_cnt = err_cnt + 1;
        $display("Enable pattern %b does not select a single digit", seg_enb);
      end
      if (idx >= 0) begin
        assert (prev < 0 || idx == prev || idx == (prev + 1) % NUM_DIGITS) else begin
          err_cnt = err_cnt + 1;
          $display("Digit scan jumped from digit %0d to digit %0d", prev, idx);
        end
        shown[idx] = seg_to_digit(seg);
        dps[idx]   = seg_dp;
        seen[idx]  = 1'b1;
        prev       = idx;
      end
      @(negedge clk);
    end
    assert (&seen) else begin
      err_cnt = err_cnt + 1;
      $display("Scan did not visit all six digits");
    end
  endtask

  task automatic expect_display(input int h, input int m, input int s, input bit dp0,
                                input bit dp1, input int blank_fld);
    int val;
    int exp_d;
    bit exp_dp;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      val    = (i < 2) ? s : (i < 4) ? m : h;
      exp_d  = (i % 2 == 1) ? val / 10 : val % 10;
      if (i / 2 == blank_fld) exp_d = 10;
      exp_dp = (i == 0) ? dp0 : (i == 1) ? dp1 : 1'b0;
      assert (shown[i] == exp_d) else begin
        err_cnt = err_cnt + 1;
        $display("Error at %0t: o_seg digit %0d expected %0d got %0d", $time, i, exp_d,
                 shown[i]);
      end
      assert (dps[i] == exp_dp) else begin
        err_cnt = err_cnt + 1;
        $display("Error at %0t: o_seg_dp digit %0d expected %b got %b", $time, i, exp_dp,
                 dps[i]);
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %s", num, name, (err_cnt == test_err) ? "ok" : "failed");
    test_err = err_cnt;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int   n;
    int   toggles;
    logic last;
    btn       = '0;
    rst_n     = 1'b0;
    model_run = 1'b1;
    en_model  = 1'b0;
    hour_ofs  = 0;
    al_h      = 0;
    al_m      = 0;
    al_s      = 0;
    err_cnt   = 0;
    test_err  = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    assert (alarm == 1'b0) else begin
      err_cnt = err_cnt + 1;
      $display("Error at %0t: o_alarm expected 0 got %b", $time, alarm);
    end
    read_display(0);
    expect_display(0, 0, 0, 1'b0, 1'b0, -1);
    end_test(1, "reset state");

    repeat (63) begin  // Crosses 59 -> next minute
      read_display(0);
      expect_display(cur_hour(), cur_min(), cur_sec(), 1'b0, 1'b0, -1);
    end
    end_test(2, "clock running");

    press(BTN_MODE);
    model_run = 1'b0;
    repeat (3) begin
      read_display(0);
      expect_display(cur_hour(), cur_min(), cur_sec(), 1'b1, 1'b0, -1);
    end
    press(BTN_POS);
    press(BTN_POS);
    n = 1 + rand_bits(5);  // At least one step
    repeat (n) press(BTN_STEP);
    hour_ofs = (hour_ofs + n) % 24;
    read_display(0);
    expect_display(cur_hour(), cur_min(), cur_sec(), 1'b1, 1'b0, -1);
    read_display(1);
    expect_display(cur_hour(), cur_min(), cur_sec(), 1'b1, 1'b0, 2);
    end_test(3, "set time");

    press(BTN_MODE);
    model_run = 1'b1;
    n = 1 + rand_bits(5);
    repeat (n) press(BTN_STEP);
    al_h = n % 24;
    read_display(0);
    expect_display(al_h, al_m, al_s, 1'b0, 1'b1, -1);
    read_display(1);
    expect_display(al_h, al_m, al_s, 1'b0, 1'b1, 2);
    n = (cur_hour() - al_h + 24) % 24;
    repeat (n) press(BTN_STEP);
    al_h = cur_hour();
    press(BTN_POS);
    press(BTN_POS);
    al_m = (cur_min() + 2) % 60;
    repeat (al_m) press(BTN_STEP);
    read_display(0);
    expect_display(al_h, al_m, al_s, 1'b0, 1'b1, -1);
    press(BTN_MODE);
    read_display(0);
    expect_display(cur_hour(), cur_min(), cur_sec(), 1'b0, 1'b0, -1);
    end_test(4, "set alarm");

    press(BTN_ALARM);
    en_model = 1'b1;
    while (!ring_model) @(negedge clk);
    toggles = 0;
    last    = alarm;
    repeat (8 * TONE_DIV) begin
      @(negedge clk);
      if (alarm != last) toggles = toggles + 1;
      last = alarm;
    end
    assert (toggles >= 4) else begin
      err_cnt = err_cnt + 1;
      $display("Alarm output did not toggle while ringing (%0d changes)", toggles);
    end
    press(BTN_ALARM);
    en_model = 1'b0;
    repeat (8 * TONE_DIV) begin
      @(negedge clk);
      assert (alarm == 1'b0) else begin
        err_cnt = err_cnt + 1;
        $display("Error at %0t: o_alarm expected 0 got %b", $time, alarm);
      end
    end
    end_test(5, "alarm");

    $display("Tests run: 5, errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
